//--- src/ecc_defs.svh
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

////////////////////////////////////////////////////////////
// Codeword geometry
////////////////////////////////////////////////////////////

`define ECC_DATA_WIDTH 32
`define ECC_CHECK_WIDTH 7
`define ECC_CODE_WIDTH 39

////////////////////////////////////////////////////////////
// Storage geometry
////////////////////////////////////////////////////////////

`define ECC_ADDR_WIDTH 6
`define ECC_MEM_DEPTH (1 << `ECC_ADDR_WIDTH)

`endif

//--- src/ecc_pkg.sv
`include "ecc_defs.svh"

package ecc_pkg;

  typedef union packed {
    logic [`ECC_CODE_WIDTH-1:0] raw;  // Flat view for masks and storage.
    struct packed {
      logic [`ECC_CHECK_WIDTH-1:0] check;
      logic [`ECC_DATA_WIDTH-1:0]  data;
    } f;
  } code_word_t;

  ////////////////////////////////////////////////////////////
  // Check matrix
  ////////////////////////////////////////////////////////////

  // One weight-3 column per data bit. Check bits use the unit vectors,
  // so every single-bit syndrome is odd and an even one is uncorrectable.
  parameter logic [`ECC_CHECK_WIDTH-1:0] H_COLS [0:`ECC_DATA_WIDTH-1] = '{
    7'h07, 7'h0b, 7'h13, 7'h23, 7'h43, 7'h0d, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0e,
    7'h16, 7'h26, 7'h46, 7'h1a, 7'h2a, 7'h4a, 7'h32, 7'h52,
    7'h62, 7'h1c, 7'h2c, 7'h4c, 7'h34, 7'h54, 7'h64, 7'h38
  };

  // Check bit m is the parity of the data bits whose column has bit m set.
  function automatic logic [`ECC_CHECK_WIDTH-1:0] calc_check(
    input logic [`ECC_DATA_WIDTH-1:0] data
  );
    logic [`ECC_CHECK_WIDTH-1:0] chk;
    chk = '0;
    for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
      if (data[i]) begin
        chk = chk ^ H_COLS[i];
      end
    end
    return chk;
  endfunction

endpackage

//--- src/ecc_code_if.sv
`timescale 1ns/1ps
`include "ecc_defs.svh"

interface ecc_code_if;

  logic                       valid;  // One cycle per transaction.
  logic                       we;
  logic [`ECC_ADDR_WIDTH-1:0] addr;
  ecc_pkg::code_word_t        code;

  modport src (
    output valid,
    output we,
    output addr,
    output code
  );

  modport snk (
    input valid,
    input we,
    input addr,
    input code
  );

endinterface

//--- src/ecc_encode.sv
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_encode (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [`ECC_ADDR_WIDTH-1:0] adr,
  input  logic [`ECC_DATA_WIDTH-1:0] dat_w,
  input  logic [`ECC_CODE_WIDTH-1:0] inject_mask,
  input  logic                       done,
  ecc_code_if.src                    code_out
);

  logic                       accept;
  logic                       busy;
  logic                       valid_r;
  logic                       we_r;
  logic [`ECC_ADDR_WIDTH-1:0] addr_r;
  ecc_pkg::code_word_t        clean;
  ecc_pkg::code_word_t        code_r;

  assign accept = cyc && stb && !busy;  // A held strobe is taken only once.

  assign clean.f.check = ecc_pkg::calc_check(dat_w);
  assign clean.f.data  = dat_w;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= 1'b0;
      busy    <= 1'b0;
    end else begin
      valid_r <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      we_r       <= we;
      addr_r     <= adr;
      code_r.raw <= clean.raw ^ (we ? inject_mask : '0);  // Faults go in on writes only.
    end
  end

  assign code_out.valid = valid_r;
  assign code_out.we    = we_r;
  assign code_out.addr  = addr_r;
  assign code_out.code  = code_r;

  // The completion from the read stage must belong to the transfer in flight.
  a_done_while_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy);

endmodule

//--- src/ecc_store.sv
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_store (
  input  logic    clk,
  input  logic    rst,
  ecc_code_if.snk code_in,
  ecc_code_if.src code_out
);

  ecc_pkg::code_word_t        mem [0:`ECC_MEM_DEPTH-1];
  ecc_pkg::code_word_t        rd_code;
  logic                       valid_r;
  logic                       we_r;
  logic [`ECC_ADDR_WIDTH-1:0] addr_r;

  ////////////////////////////////////////////////////////////
  // Array and read register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (code_in.valid && code_in.we) begin
      mem[code_in.addr] <= code_in.code;
    end
    if (code_in.valid && !code_in.we) begin
      rd_code <= mem[code_in.addr];
    end
    if (code_in.valid) begin
      addr_r <= code_in.addr;
    end
  end

  // Writes pass a done marker downstream so every transfer has the same latency.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= 1'b0;
      we_r    <= 1'b0;
    end else begin
      valid_r <= code_in.valid;
      we_r    <= code_in.we;
    end
  end

  assign code_out.valid = valid_r;
  assign code_out.we    = we_r;
  assign code_out.addr  = addr_r;
  assign code_out.code  = rd_code;

endmodule

//--- src/ecc_dec_fix.sv
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_dec_fix (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       correct_en,
  ecc_code_if.snk                    code_in,
  output logic [`ECC_DATA_WIDTH-1:0] dat_r,
  output logic                       ack,
  output logic                       ecc_single,
  output logic                       ecc_multiple,
  output logic                       done
);

  logic [`ECC_CHECK_WIDTH-1:0] syndrome_ns;
  logic [`ECC_CHECK_WIDTH-1:0] syndrome_r;
  logic [`ECC_DATA_WIDTH-1:0]  data_r;
  logic [`ECC_DATA_WIDTH-1:0]  flip_bits;
  logic                        valid_r;
  logic                        rd_r;
  logic                        syn_nonzero;
  logic                        syn_odd;

  ////////////////////////////////////////////////////////////
  // Syndrome stage
  ////////////////////////////////////////////////////////////

  assign syndrome_ns = code_in.code.f.check ^ ecc_pkg::calc_check(code_in.code.f.data);

  always_ff @(posedge clk) begin
    syndrome_r <= syndrome_ns;  // Registered with the payload.
    data_r     <= code_in.code.f.data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r <= 1'b0;
      rd_r    <= 1'b0;
    end else begin
      valid_r <= code_in.valid;
      rd_r    <= code_in.valid && !code_in.we;
    end
  end

  ////////////////////////////////////////////////////////////
  // Correction and status
  ////////////////////////////////////////////////////////////

  // At most one column can match; an even syndrome matches none.
  always_comb begin
    for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
      flip_bits[i] = (ecc_pkg::H_COLS[i] == syndrome_r);
    end
  end

  assign dat_r = correct_en ? (data_r ^ flip_bits) : data_r;

  assign syn_nonzero = |syndrome_r;
  assign syn_odd     = ^syndrome_r;

  assign ecc_single   = valid_r && rd_r && syn_nonzero && syn_odd;
  assign ecc_multiple = valid_r && rd_r && syn_nonzero && !syn_odd;

  assign ack  = valid_r;
  assign done = valid_r;  // Releases the request stage.

  // An uncorrectable word must never have a data bit repaired.
  a_multiple_no_fix: assert property (
    @(posedge clk) disable iff (rst) ecc_multiple |-> (flip_bits == '0)
  );

  // One transfer in flight means the acknowledge never stretches.
  a_ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

endmodule

//--- src/ecc_mem_top.sv
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_mem_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cyc,
  input  logic                       stb,
  input  logic                       we,
  input  logic [`ECC_ADDR_WIDTH-1:0] adr,
  input  logic [`ECC_DATA_WIDTH-1:0] dat_w,
  input  logic [`ECC_CODE_WIDTH-1:0] inject_mask,
  input  logic                       correct_en,
  output logic [`ECC_DATA_WIDTH-1:0] dat_r,
  output logic                       ack,
  output logic                       ecc_single,
  output logic                       ecc_multiple
);

  logic done;

  ecc_code_if enc_to_store ();
  ecc_code_if store_to_dec ();  // Valid here carries read data or a write marker.

  ////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////

  ecc_encode u_encode (
    .clk         (clk),
    .rst         (rst),
    .cyc         (cyc),
    .stb         (stb),
    .we          (we),
    .adr         (adr),
    .dat_w       (dat_w),
    .inject_mask (inject_mask),
    .done        (done),
    .code_out    (enc_to_store.src)
  );

  ecc_store u_store (
    .clk      (clk),
    .rst      (rst),
    .code_in  (enc_to_store.snk),
    .code_out (store_to_dec.src)
  );

  ecc_dec_fix u_dec_fix (
    .clk          (clk),
    .rst          (rst),
    .correct_en   (correct_en),
    .code_in      (store_to_dec.snk),
    .dat_r        (dat_r),
    .ack          (ack),
    .ecc_single   (ecc_single),
    .ecc_multiple (ecc_multiple),
    .done         (done)
  );

endmodule

//--- dv/ecc_mem_tb.sv
`timescale 1ns/1ps
`include "ecc_defs.svh"

module ecc_mem_tb;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_ROWS        = 20;
  localparam int ACK_EDGE        = 3;  // Request sampled at edge 0, ack sampled at edge 3.
  localparam int MAX_WAIT        = 8;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 10 + RESET_CYCLES;

  typedef struct {
    logic                       is_write;
    logic [`ECC_ADDR_WIDTH-1:0] addr;
    logic [`ECC_DATA_WIDTH-1:0] data;
    logic [`ECC_CODE_WIDTH-1:0] mask;
    logic                       correct_en;
    logic [`ECC_DATA_WIDTH-1:0] exp_data;
    logic                       exp_single;
    logic                       exp_multiple;
  } row_t;

  logic                       clk;
  logic                       rst;
  logic                       cyc;
  logic                       stb;
  logic                       we;
  logic [`ECC_ADDR_WIDTH-1:0] adr;
  logic [`ECC_DATA_WIDTH-1:0] dat_w;
  logic [`ECC_CODE_WIDTH-1:0] inject_mask;
  logic                       correct_en;
  logic [`ECC_DATA_WIDTH-1:0] dat_r;
  logic                       ack;
  logic                       ecc_single;
  logic                       ecc_multiple;

  row_t                       rows [NUM_ROWS];
  logic [`ECC_CODE_WIDTH-1:0] shadow [0:`ECC_MEM_DEPTH-1];  // Model of the stored codewords.
  logic [31:0]                rng_state;
  int                         row_count = 0;
  int                         checks = 0;
  int                         errors = 0;
  int                         ack_count = 0;

  ecc_mem_top UUT (
    .clk          (clk),
    .rst          (rst),
    .cyc          (cyc),
    .stb          (stb),
    .we           (we),
    .adr          (adr),
    .dat_w        (dat_w),
    .inject_mask  (inject_mask),
    .correct_en   (correct_en),
    .dat_r        (dat_r),
    .ack          (ack),
    .ecc_single   (ecc_single),
    .ecc_multiple (ecc_multiple)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst && ack) begin
      ack_count++;  // Ack is a one-cycle pulse, so each one is counted once.
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Check bit m is the parity of the data bits whose column has bit m set.
  function automatic logic [`ECC_CHECK_WIDTH-1:0] model_check_bits(
    input logic [`ECC_DATA_WIDTH-1:0] data
  );
    logic [`ECC_CHECK_WIDTH-1:0] chk;
    for (int m = 0; m < `ECC_CHECK_WIDTH; m++) begin
      chk[m] = 1'b0;
      for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
        chk[m] = chk[m] ^ (data[i] & ecc_pkg::H_COLS[i][m]);
      end
    end
    return chk;
  endfunction

  function automatic logic [`ECC_CODE_WIDTH-1:0] flip(input int pos);
    return {{(`ECC_CODE_WIDTH-1){1'b0}}, 1'b1} << pos;
  endfunction

  task automatic add_row(input logic is_write, input logic [`ECC_ADDR_WIDTH-1:0] addr,
                         input logic use_rand, input logic [`ECC_DATA_WIDTH-1:0] data,
                         input logic [`ECC_CODE_WIDTH-1:0] mask, input logic ce);
    rows[row_count].is_write   = is_write;
    rows[row_count].addr       = addr;
    rows[row_count].data       = data;
    rows[row_count].mask       = mask;
    rows[row_count].correct_en = ce;
    if (use_rand) begin
      rng_state                = xorshift32(rng_state);
      rows[row_count].data     = rng_state;
    end
    row_count++;
  endtask

  // Walks the table in order and fills in what each read must return.
  task automatic resolve_expected();
    logic [`ECC_CODE_WIDTH-1:0]  word;
    logic [`ECC_CHECK_WIDTH-1:0] syn;
    logic [`ECC_DATA_WIDTH-1:0]  data;
    for (int r = 0; r < NUM_ROWS; r++) begin
      rows[r].exp_data     = '0;
      rows[r].exp_single   = 1'b0;
      rows[r].exp_multiple = 1'b0;
      if (rows[r].is_write) begin
        word = {model_check_bits(rows[r].data), rows[r].data} ^ rows[r].mask;
        shadow[rows[r].addr] = word;
      end else begin
        word = shadow[rows[r].addr];
        data = word[`ECC_DATA_WIDTH-1:0];
        syn  = word[`ECC_CODE_WIDTH-1:`ECC_DATA_WIDTH] ^ model_check_bits(data);
        if (rows[r].correct_en) begin
          for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (ecc_pkg::H_COLS[i] == syn) begin
              data[i] = ~data[i];
            end
          end
        end
        rows[r].exp_data     = data;
        rows[r].exp_single   = (syn != '0) && (^syn);
        rows[r].exp_multiple = (syn != '0) && !(^syn);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Wishbone transfer
  ////////////////////////////////////////////////////////////

  task automatic run_transfer(input int r);
    int   edges;
    logic seen;
    @(negedge clk);
    cyc         = 1'b1;
    stb         = 1'b1;
    we          = rows[r].is_write;
    adr         = rows[r].addr;
    dat_w       = rows[r].data;
    inject_mask = rows[r].mask;
    correct_en  = rows[r].correct_en;
    edges       = 0;
    seen        = 1'b0;
    while (!seen && edges < MAX_WAIT) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      checks++;
      if (ack) begin
        seen = 1'b1;
      end else if (ecc_single || ecc_multiple) begin
        errors++;
        $display("ERROR: row %0d has a status flag high outside the ack cycle", r);
      end
    end
    if (!seen) begin
      errors++;
      $display("ERROR: row %0d got no ack within %0d cycles", r, MAX_WAIT);
    end else begin
      checks += 3;
      if (edges != ACK_EDGE) begin
        errors++;
        $display("MISMATCH row %0d ack edge: expected 0x%0h, got 0x%0h", r, ACK_EDGE, edges);
      end
      if (ecc_single !== rows[r].exp_single) begin
        errors++;
        $display("MISMATCH row %0d ecc_single: expected 0x%0h, got 0x%0h",
                 r, rows[r].exp_single, ecc_single);
      end
      if (ecc_multiple !== rows[r].exp_multiple) begin
        errors++;
        $display("MISMATCH row %0d ecc_multiple: expected 0x%0h, got 0x%0h",
                 r, rows[r].exp_multiple, ecc_multiple);
      end
      if (!rows[r].is_write) begin
        checks++;
        if (dat_r !== rows[r].exp_data) begin
          errors++;
          $display("MISMATCH row %0d dat_r: expected 0x%08h, got 0x%08h",
                   r, rows[r].exp_data, dat_r);
        end
      end
      @(posedge clk);  // Master samples ack here.
      @(negedge clk);
    end
    cyc = 1'b0;
    stb = 1'b0;
    checks++;
    if (ack) begin
      errors++;
      $display("ERROR: row %0d ack stayed high for more than one cycle", r);
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d clock cycles", WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d, acks: %0d", checks, errors + 1, ack_count);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst         = 1'b1;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    dat_w       = '0;
    inject_mask = '0;
    correct_en  = 1'b0;
    rng_state   = 32'd48;

    add_row(1'b1, 6'h00, 1'b0, 32'h1234_5678, '0, 1'b0);
    add_row(1'b1, 6'h15, 1'b1, 32'h0, '0, 1'b0);
    add_row(1'b1, 6'h2a, 1'b1, 32'h0, '0, 1'b0);
    add_row(1'b1, 6'h3f, 1'b0, 32'hdead_beef, '0, 1'b0);
    add_row(1'b0, 6'h00, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b0, 6'h15, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b0, 6'h2a, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b0, 6'h3f, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b1, 6'h05, 1'b1, 32'h0, flip(7), 1'b0);        // Single data-bit fault.
    add_row(1'b0, 6'h05, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b0, 6'h05, 1'b0, 32'h0, '0, 1'b0);
    add_row(1'b1, 6'h06, 1'b1, 32'h0, flip(35), 1'b0);       // Check-bit fault.
    add_row(1'b0, 6'h06, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b1, 6'h07, 1'b1, 32'h0, flip(3) | flip(20), 1'b0);
    add_row(1'b0, 6'h07, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b1, 6'h08, 1'b0, 32'ha5a5_a5a5, flip(0) | flip(34), 1'b0);
    add_row(1'b0, 6'h08, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b1, 6'h09, 1'b1, 32'h0, flip(31), 1'b0);
    add_row(1'b0, 6'h09, 1'b0, 32'h0, '0, 1'b1);
    add_row(1'b0, 6'h3f, 1'b0, 32'h0, '0, 1'b0);
    resolve_expected();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    checks++;
    if (ack || ecc_single || ecc_multiple) begin
      errors++;
      $display("ERROR: ack or a status flag is high during reset");
    end
    rst = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_transfer(r);
    end
    repeat (2) @(negedge clk);

    checks++;
    if (ack_count != NUM_ROWS) begin
      errors++;
      $display("MISMATCH ack count: expected 0x%0h, got 0x%0h", NUM_ROWS, ack_count);
    end
    $display("Checks: %0d, errors: %0d, acks: %0d", checks, errors, ack_count);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+src
src/ecc_pkg.sv
src/ecc_code_if.sv
src/ecc_encode.sv
src/ecc_store.sv
src/ecc_dec_fix.sv
src/ecc_mem_top.sv
dv/ecc_mem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the ECC memory testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ecc_mem_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -f vlog.f --top-module ecc_mem_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status."
  exit 1
fi

grep -qF '*** PASSED ***' "$LOG_FILE"
if [ $? -ne 0 ]; then
  echo "Pass message not found in $LOG_FILE."
  exit 1
fi

echo "Simulation passed."
exit 0
